//--- rtl/spi_bit_engine.sv
`timescale 1ns/1ps

module spi_bit_engine
	import spi_cfg_pkg::*;
(
	input  logic                 CLK50MHZ,
	input  logic                 RST,
	// Command side
	input  logic                 start,
	input  logic [spi_width-1:0] tx_word,
	// SPI pins
	input  logic                 spi_miso,
	output logic                 spi_sck,
	output logic                 spi_cs,
	output logic                 spi_mosi,
	// Status and result
	output logic                 busy,
	output logic                 frame_done,
	output logic [spi_width-1:0] rx_word
);

	spi_state_t           state;
	logic [div_cnt_w-1:0] div_cnt;
	logic [bit_cnt_w-1:0] bit_cnt;
	logic [spi_width-1:0] shreg;
	logic                 miso_q;
	logic                 half_end;
	logic                 last_bit;

	// End of an SCK half period
	assign half_end = (div_cnt == div_cnt_w'(sck_half - 1));
	// All rising edges of the frame seen
	assign last_bit = (bit_cnt == bit_cnt_w'(spi_width));

	//////////////////////////////////////////////////
	// Control FSM
	//////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state      <= st_idle;
			spi_cs     <= 1'b1;
			spi_sck    <= 1'b0;
			frame_done <= 1'b0;
			div_cnt    <= '0;
			bit_cnt    <= '0;
		end else begin
			// Single cycle pulse by default
			frame_done <= 1'b0;
			case (state)
				st_idle: begin
					// Start while busy never reaches here
					if (start) begin
						state   <= st_shift;
						spi_cs  <= 1'b0;
						div_cnt <= '0;
						bit_cnt <= '0;
					end
				end
				st_shift: begin
					if (half_end) begin
						div_cnt <= '0;
						spi_sck <= !spi_sck;
						if (!spi_sck) begin
							// Rising edge counted
							bit_cnt <= bit_cnt + 1'b1;
						end else if (last_bit) begin
							// Last falling edge ends the frame
							state <= st_done;
						end
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end
				st_done: begin
					// CS release with the done pulse
					state      <= st_idle;
					spi_cs     <= 1'b1;
					frame_done <= 1'b1;
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Shift register
	//////////////////////////////////////////////////

	// MISO sampled on rising SCK, shifted in on falling
	always_ff @(posedge CLK50MHZ) begin
		if ((state == st_idle) && start) begin
			shreg <= tx_word;
		end else if ((state == st_shift) && half_end) begin
			if (!spi_sck) begin
				miso_q <= spi_miso;
			end else begin
				shreg <= {shreg[spi_width-2:0], miso_q};
			end
		end
	end

	// MSB first, line parks high
	assign spi_mosi = (state == st_shift) ? shreg[spi_width-1] : 1'b1;
	assign busy     = (state != st_idle);
	// Full word after the last shift
	assign rx_word  = shreg;

	// CS released while idle
	a_idle_cs_high: assert property (
		@(posedge CLK50MHZ) disable iff (RST)
		(state == st_idle) |-> spi_cs
	);

	// No SCK pulse outside a frame
	a_sck_low_no_cs: assert property (
		@(posedge CLK50MHZ) disable iff (RST)
		spi_cs |-> !spi_sck
	);

endmodule

//--- rtl/spi_cfg_pkg.sv
package spi_cfg_pkg;

	//////////////////////////////////////////////////
	// Frame and clock setup
	//////////////////////////////////////////////////

	// Bits needed to hold a count up to value
	function automatic int bits_for(input int value);
		int n;
		n = 1;
		while ((1 << n) <= value) begin
			n = n + 1;
		end
		return n;
	endfunction

	// Frame length in bits
	localparam int spi_width = 32;

	// System clocks per SCK half period
	localparam int sck_half = 2;

	// Counts rising edges up to spi_width
	localparam int bit_cnt_w = bits_for(spi_width);

	// Half period counter runs 0 to sck_half-1
	localparam int div_cnt_w = bits_for(sck_half - 1);

	// Engine states
	typedef enum logic [1:0] {
		st_idle,
		st_shift,
		st_done
	} spi_state_t;

endpackage

//--- rtl/spi_rx_capture.sv
`timescale 1ns/1ps

module spi_rx_capture
	import spi_cfg_pkg::*;
(
	input  logic                 CLK50MHZ,
	input  logic                 RST,
	// From the engine
	input  logic                 frame_done,
	input  logic [spi_width-1:0] rx_word,
	// From the register decode
	input  logic                 rx_clear,
	// Back to the register decode
	output logic [spi_width-1:0] rx_data,
	output logic                 done,
	output logic                 overrun
);

	//////////////////////////////////////////////////
	// Sticky flags
	//////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			done    <= 1'b0;
			overrun <= 1'b0;
		end else if (frame_done) begin
			// New frame beats a clear in the same cycle
			done    <= 1'b1;
			// Unread word gets overwritten
			overrun <= (overrun || done) && !rx_clear;
		end else if (rx_clear) begin
			done    <= 1'b0;
			overrun <= 1'b0;
		end
	end

	// Received word latch
	always_ff @(posedge CLK50MHZ) begin
		if (frame_done) begin
			rx_data <= rx_word;
		end
	end

	// Overrun implies an unread word
	a_overrun_needs_done: assert property (
		@(posedge CLK50MHZ) disable iff (RST)
		overrun |-> done
	);

endmodule

//--- rtl/spi_wb_top.sv
`timescale 1ns/1ps

module spi_wb_top
	import spi_cfg_pkg::*;
	import wb_map_pkg::*;
(
	input  logic                            CLK50MHZ,
	input  logic                            RST,
	// Wishbone classic slave
	input  logic                            wb_cyc,
	input  logic                            wb_stb,
	input  logic                            wb_we,
	input  logic [wb_adr_w-1:0]             wb_adr,
	input  logic [wb_map_pkg::wb_dat_w-1:0] wb_dat_w,
	output logic [wb_map_pkg::wb_dat_w-1:0] wb_dat_r,
	output logic                            wb_ack,
	// SPI pins
	output logic                            spi_sck,
	output logic                            spi_cs,
	output logic                            spi_mosi,
	input  logic                            spi_miso
);

	// Decode to engine
	logic [spi_width-1:0] tx_word;
	logic                 start;
	logic                 busy;
	// Engine to capture
	logic [spi_width-1:0] rx_word;
	logic                 frame_done;
	// Capture and decode
	logic                 rx_clear;
	logic [spi_width-1:0] rx_data;
	logic                 done;
	logic                 overrun;

	//////////////////////////////////////////////////
	// Blocks
	//////////////////////////////////////////////////

	wb_reg_decode u_decode (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.tx_word  (tx_word),
		.start    (start),
		.rx_clear (rx_clear),
		.busy     (busy),
		.rx_data  (rx_data),
		.done     (done),
		.overrun  (overrun)
	);

	spi_bit_engine u_engine (
		.CLK50MHZ   (CLK50MHZ),
		.RST        (RST),
		.start      (start),
		.tx_word    (tx_word),
		.spi_miso   (spi_miso),
		.spi_sck    (spi_sck),
		.spi_cs     (spi_cs),
		.spi_mosi   (spi_mosi),
		.busy       (busy),
		.frame_done (frame_done),
		.rx_word    (rx_word)
	);

	spi_rx_capture u_capture (
		.CLK50MHZ   (CLK50MHZ),
		.RST        (RST),
		.frame_done (frame_done),
		.rx_word    (rx_word),
		.rx_clear   (rx_clear),
		.rx_data    (rx_data),
		.done       (done),
		.overrun    (overrun)
	);

endmodule

//--- rtl/wb_map_pkg.sv
package wb_map_pkg;

	//////////////////////////////////////////////////
	// Wishbone bus widths
	//////////////////////////////////////////////////

	// Byte address
	localparam int wb_adr_w = 4;
	localparam int wb_dat_w = 32;

	//////////////////////////////////////////////////
	// Register map
	//////////////////////////////////////////////////

	// Transmit word, read/write
	localparam logic [wb_adr_w-1:0] reg_txdata = 4'h0;
	// Bit 0 written high starts a frame
	localparam logic [wb_adr_w-1:0] reg_ctrl = 4'h4;
	// Received word, read only
	localparam logic [wb_adr_w-1:0] reg_rxdata = 4'h8;
	// Flags, read only
	localparam logic [wb_adr_w-1:0] reg_status = 4'hC;

	// Status bit positions
	localparam int st_done = 0;
	localparam int st_busy = 1;
	localparam int st_overrun = 2;

endpackage

//--- rtl/wb_reg_decode.sv
`timescale 1ns/1ps

module wb_reg_decode
	import spi_cfg_pkg::*;
	import wb_map_pkg::*;
(
	input  logic                              CLK50MHZ,
	input  logic                              RST,
	// Wishbone classic slave
	input  logic                              wb_cyc,
	input  logic                              wb_stb,
	input  logic                              wb_we,
	input  logic [wb_adr_w-1:0]               wb_adr,
	input  logic [wb_map_pkg::wb_dat_w-1:0]   wb_dat_w,
	output logic [wb_map_pkg::wb_dat_w-1:0]   wb_dat_r,
	output logic                              wb_ack,
	// Towards the engine
	output logic [spi_width-1:0]              tx_word,
	output logic                              start,
	output logic                              rx_clear,
	// Back from engine and capture
	input  logic                              busy,
	input  logic [spi_width-1:0]              rx_data,
	input  logic                              done,
	input  logic                              overrun
);

	logic                            req;
	logic                            new_req;
	logic [spi_width-1:0]            tx_reg;
	logic [wb_map_pkg::wb_dat_w-1:0] status_word;
	logic [wb_map_pkg::wb_dat_w-1:0] rd_mux;

	// Bus cycle seen
	assign req = wb_cyc && wb_stb;
	// First cycle only, ack not yet given
	assign new_req = req && !wb_ack;

	//////////////////////////////////////////////////
	// Ack, TXDATA and command pulses
	//////////////////////////////////////////////////

	// Pulses line up with the ack cycle
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			wb_ack   <= 1'b0;
			start    <= 1'b0;
			rx_clear <= 1'b0;
			tx_reg   <= '0;
		end else begin
			wb_ack   <= new_req;
			start    <= new_req && wb_we && (wb_adr == reg_ctrl) && wb_dat_w[0];
			rx_clear <= new_req && !wb_we && (wb_adr == reg_rxdata);
			// TXDATA write
			if (new_req && wb_we && (wb_adr == reg_txdata)) begin
				tx_reg <= wb_dat_w[spi_width-1:0];
			end
		end
	end

	assign tx_word = tx_reg;

	//////////////////////////////////////////////////
	// Read path
	//////////////////////////////////////////////////

	// Status word from package bit positions
	always_comb begin
		status_word                         = '0;
		status_word[wb_map_pkg::st_done]    = done;
		status_word[wb_map_pkg::st_busy]    = busy;
		status_word[wb_map_pkg::st_overrun] = overrun;
	end

	// Register select
	always_comb begin
		rd_mux = '0;
		case (wb_adr)
			reg_txdata: rd_mux[spi_width-1:0] = tx_reg;
			reg_rxdata: rd_mux[spi_width-1:0] = rx_data;
			reg_status: rd_mux = status_word;
			// CTRL and holes read zero
			default:    rd_mux = '0;
		endcase
	end

	// Read data held for the ack cycle
	always_ff @(posedge CLK50MHZ) begin
		if (new_req && !wb_we) begin
			wb_dat_r <= rd_mux;
		end
	end

	// Ack one cycle after a bus request and never two in a row
	a_ack_after_req: assert property (
		@(posedge CLK50MHZ) disable iff (RST)
		wb_ack |-> ($past(wb_cyc && wb_stb) && !$past(wb_ack))
	);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the SPI Wishbone testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

top=tb_spi_wb
build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module "$top" --Mdir "$build_dir" -o "$top" -f sources.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$build_dir/$top" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

# Verdict comes from the log
if grep -q "TB FAILED" "$log_file"; then
	echo "Simulation reported a failure, see $log_file"
	exit 1
fi
echo "Simulation finished without failures"
exit 0

//--- sources.f
rtl/spi_cfg_pkg.sv
rtl/wb_map_pkg.sv
rtl/wb_reg_decode.sv
rtl/spi_bit_engine.sv
rtl/spi_rx_capture.sv
rtl/spi_wb_top.sv
verif/spi_slave_model.sv
verif/tb_spi_wb.sv

//--- verif/spi_slave_model.sv
`timescale 1ns/1ps

module spi_slave_model
	import spi_cfg_pkg::*;
(
	// SPI pins, mode 0
	input  logic                 spi_sck,
	input  logic                 spi_cs,
	input  logic                 spi_mosi,
	output logic                 spi_miso,
	// Last completed frame as seen on MOSI
	output logic [spi_width-1:0] last_frame,
	output int                   last_bits,
	output int                   frame_count
);

	// Answer before any frame has been received
	localparam logic [spi_width-1:0] reset_word = 32'hA5A5_5A5A;

	logic [spi_width-1:0] rx_sh = '0;
	logic [spi_width-1:0] tx_sh = reset_word;
	logic [spi_width-1:0] seen_frame = '0;
	int                   rx_bits = 0;
	int                   seen_bits = 0;
	int                   frames = 0;

	//////////////////////////////////////////////////
	// Receive side
	//////////////////////////////////////////////////

	// MOSI taken on rising SCK, frame closed on CS release
	always @(posedge spi_sck or posedge spi_cs) begin
		if (spi_cs === 1'b1) begin
			// Select without clocks is not a frame
			if (rx_bits != 0) begin
				seen_frame <= rx_sh;
				seen_bits  <= rx_bits;
				frames     <= frames + 1;
			end
			rx_sh   <= '0;
			rx_bits <= 0;
		end else begin
			rx_sh   <= {rx_sh[spi_width-2:0], spi_mosi};
			rx_bits <= rx_bits + 1;
		end
	end

	//////////////////////////////////////////////////
	// Transmit side
	//////////////////////////////////////////////////

	// Next answer is the frame just received
	always @(negedge spi_sck or posedge spi_cs) begin
		if (spi_cs !== 1'b0) begin
			if (rx_bits != 0) begin
				tx_sh <= rx_sh;
			end
		end else begin
			// Falling SCK moves to the next bit
			tx_sh <= {tx_sh[spi_width-2:0], 1'b0};
		end
	end

	// MSB first
	assign spi_miso    = tx_sh[spi_width-1];
	assign last_frame  = seen_frame;
	assign last_bits   = seen_bits;
	assign frame_count = frames;

endmodule

//--- verif/tb_spi_wb.sv
`timescale 1ns/1ps

module tb_spi_wb
	import spi_cfg_pkg::*;
	import wb_map_pkg::*;
();

	// CS low from first MOSI bit through the release cycle
	localparam int cs_low_cycles = 2 * sck_half * spi_width + 1;
	// Bus limit in clocks, transfer limit in STATUS polls
	localparam int ack_limit = 16;
	localparam int done_limit = 4 * sck_half * spi_width;
	localparam int random_words = 20;
	// Slave answer before its first frame
	localparam logic [31:0] model_reset_word = 32'hA5A5_5A5A;
	// STATUS masks
	localparam logic [31:0] status_done = 32'(1) << wb_map_pkg::st_done;
	localparam logic [31:0] status_busy = 32'(1) << wb_map_pkg::st_busy;
	localparam logic [31:0] status_overrun = 32'(1) << wb_map_pkg::st_overrun;

	logic                 CLK50MHZ;
	logic                 RST;
	logic                 wb_cyc;
	logic                 wb_stb;
	logic                 wb_we;
	logic [wb_adr_w-1:0]  wb_adr;
	logic [wb_dat_w-1:0]  wb_wdata;
	logic [wb_dat_w-1:0]  wb_rdata;
	logic                 wb_ack;
	logic                 spi_sck;
	logic                 spi_cs;
	logic                 spi_mosi;
	logic                 spi_miso;
	// Slave model view
	logic [spi_width-1:0] slave_frame;
	int                   slave_bits;
	int                   slave_frames;

	int                   check_count = 0;
	int                   mismatch_count = 0;
	int                   timeout_count = 0;
	int                   low_count = 0;
	int                   seed;
	// Frames sent so far and the last MOSI word
	int                   sent_frames = 0;
	logic [31:0]          prev_word = '0;

	spi_wb_top dut (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_wdata),
		.wb_dat_r (wb_rdata),
		.wb_ack   (wb_ack),
		.spi_sck  (spi_sck),
		.spi_cs   (spi_cs),
		.spi_mosi (spi_mosi),
		.spi_miso (spi_miso)
	);

	spi_slave_model u_slave (
		.spi_sck     (spi_sck),
		.spi_cs      (spi_cs),
		.spi_mosi    (spi_mosi),
		.spi_miso    (spi_miso),
		.last_frame  (slave_frame),
		.last_bits   (slave_bits),
		.frame_count (slave_frames)
	);

	// 50 MHz
	always #10 CLK50MHZ = ~CLK50MHZ;

	//////////////////////////////////////////////////
	// Reference and compare
	//////////////////////////////////////////////////

	// MISO echoes the previous MOSI frame
	function automatic logic [31:0] expected_rx(input int frames_before, input logic [31:0] prev);
		if (frames_before == 0) begin
			return model_reset_word;
		end else begin
			return prev;
		end
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			mismatch_count++;
			$display("[FAIL] %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
		end
	endtask

	// Length of every frame on spi_cs, sampled mid-cycle
	always @(negedge CLK50MHZ) begin
		if (RST) begin
			low_count = 0;
		end else if (!spi_cs) begin
			low_count++;
		end else if (low_count != 0) begin
			compare_value("spi_cs low cycles", low_count, cs_low_cycles);
			low_count = 0;
		end
	end

	//////////////////////////////////////////////////
	// Wishbone master
	//////////////////////////////////////////////////

	task automatic wait_ack(input string what);
		int cycles;
		cycles = 0;
		// Ack due one clock after the request
		@(negedge CLK50MHZ);
		while (!wb_ack && cycles < ack_limit) begin
			@(negedge CLK50MHZ);
			cycles++;
		end
		if (!wb_ack) begin
			timeout_count++;
			$display("Timeout: no Wishbone ack for %s at %0t", what, $time);
		end
	endtask

	task automatic wb_write(input logic [wb_adr_w-1:0] adr, input logic [31:0] data);
		@(negedge CLK50MHZ);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = adr;
		wb_wdata = data;
		wait_ack("a write");
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_read(input logic [wb_adr_w-1:0] adr, output logic [31:0] data);
		@(negedge CLK50MHZ);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = adr;
		wait_ack("a read");
		// Read data valid in the ack cycle
		data   = wb_rdata;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Transfer helpers
	//////////////////////////////////////////////////

	// Busy drops one clock before done shows
	task automatic wait_done();
		logic [31:0] status;
		int          polls;
		polls = 0;
		wb_read(reg_status, status);
		while (((status & (status_busy | status_done)) != status_done) && polls < done_limit) begin
			wb_read(reg_status, status);
			polls++;
		end
		if ((status & (status_busy | status_done)) != status_done) begin
			timeout_count++;
			$display("Timeout: SPI transfer did not finish at %0t", $time);
		end
	endtask

	task automatic start_transfer(input logic [31:0] word);
		logic [31:0] rd;
		wb_write(reg_txdata, word);
		wb_read(reg_txdata, rd);
		compare_value("TXDATA readback", rd, word);
		wb_write(reg_ctrl, 32'h1);
	endtask

	// One more slave frame, MSB first, full width
	task automatic check_frame(input logic [31:0] word, output logic [31:0] exp);
		compare_value("slave frame count", slave_frames, sent_frames + 1);
		compare_value("slave bit count", slave_bits, spi_width);
		compare_value("MOSI frame", slave_frame, word);
		exp = expected_rx(sent_frames, prev_word);
		sent_frames++;
		prev_word = word;
	endtask

	task automatic transfer_and_check(input logic [31:0] word);
		logic [31:0] exp;
		logic [31:0] rd;
		start_transfer(word);
		wait_done();
		check_frame(word, exp);
		wb_read(reg_status, rd);
		compare_value("STATUS after frame", rd, status_done);
		wb_read(reg_rxdata, rd);
		compare_value("RXDATA", rd, exp);
		// Read clears done
		wb_read(reg_status, rd);
		compare_value("STATUS after RXDATA read", rd, 32'h0);
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin
		logic [31:0] rd;
		logic [31:0] word;
		logic [31:0] exp_a;
		logic [31:0] exp_b;
		CLK50MHZ = 1'b0;
		RST      = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_wdata = '0;
		seed     = 99;
		repeat (5) @(negedge CLK50MHZ);
		RST = 1'b0;

		// Reset state
		compare_value("spi_cs", 32'(spi_cs), 32'h1);
		compare_value("spi_sck", 32'(spi_sck), 32'h0);
		compare_value("spi_mosi", 32'(spi_mosi), 32'h1);
		compare_value("wb_ack", 32'(wb_ack), 32'h0);
		wb_read(reg_status, rd);
		compare_value("STATUS after reset", rd, 32'h0);
		wb_read(reg_txdata, rd);
		compare_value("TXDATA after reset", rd, 32'h0);

		// First frame gets the model reset word
		transfer_and_check(32'h1234_5678);

		// Two frames unread
		word = 32'h0F1E_2D3C;
		start_transfer(word);
		wait_done();
		check_frame(word, exp_a);
		word = 32'hC3B4_A596;
		start_transfer(word);
		wait_done();
		check_frame(word, exp_b);
		wb_read(reg_status, rd);
		compare_value("STATUS with overrun", rd, status_done | status_overrun);
		wb_read(reg_rxdata, rd);
		compare_value("RXDATA after overrun", rd, exp_b);
		wb_read(reg_status, rd);
		compare_value("STATUS after overrun clear", rd, 32'h0);

		// Start while busy is dropped
		word = 32'h8001_7FFE;
		start_transfer(word);
		wb_read(reg_status, rd);
		compare_value("STATUS busy bit", rd & status_busy, status_busy);
		wb_write(reg_ctrl, 32'h1);
		wait_done();
		check_frame(word, exp_a);
		wb_read(reg_status, rd);
		compare_value("STATUS after busy start", rd, status_done);
		wb_read(reg_rxdata, rd);
		compare_value("RXDATA after busy start", rd, exp_a);
		wb_read(reg_status, rd);
		compare_value("STATUS after busy start clear", rd, 32'h0);

		// Random words
		repeat (random_words) begin
			word = $random(seed);
			transfer_and_check(word);
		end

		$display("Checks: %0d, mismatches: %0d, timeouts: %0d",
			check_count, mismatch_count, timeout_count);
		if (mismatch_count == 0 && timeout_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule
